// File: Makefile
# Verilator build and run for the UDP receive filter

VERILATOR  ?= verilator
TOP        ?= udp_rx_tb
FILELIST   ?= udp_rx.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/rx_app_writer.sv
module rx_app_writer (
  input  logic                   mac_clk,
  input  logic                   mac_rst,
  input  logic                   pay_valid,
  input  logic [63:0]            pay_data,
  input  logic                   pay_good,
  input  logic                   pay_bad,
  input  udp_rx_pkg::ipv4_addr_t src_ip,
  input  udp_rx_pkg::udp_port_t  src_port,
  input  logic                   data_afull,
  input  logic                   meta_afull,
  input  logic                   app_rx_overrun_ack,
  output logic                   data_wr_en,
  output udp_rx_pkg::app_word_t  data_wr,
  output logic                   meta_wr_en,
  output udp_rx_pkg::app_meta_t  meta_wr
);

  import udp_rx_pkg::*;

  ovr_state_t ovr_state;

  // set between the first and the last word the filter sends
  logic mid_frame;
  logic afull;
  logic pay_end;

  assign afull   = data_afull || meta_afull;
  assign pay_end = pay_good || pay_bad;

  assign data_wr_en = pay_valid && (ovr_state == OVR_RUN);

  // run is only entered between frames, so a word with no open
  // frame behind it is always the first one
  assign meta_wr_en = data_wr_en && !mid_frame;

  // a word written near full closes the frame early
  assign data_wr = '{
    overrun: afull,
    bad:     pay_bad,
    eof:     pay_end || afull,
    data:    pay_data
  };

  assign meta_wr = '{
    src_port: src_port,
    src_ip:   src_ip
  };

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      mid_frame <= 1'b0;
    end else if (pay_valid) begin
      mid_frame <= !pay_end;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      ovr_state <= OVR_RUN;
    end else begin
      case (ovr_state)
        OVR_RUN: begin
          if (pay_valid && afull) begin
            ovr_state <= OVR_OVER;
          end
        end
        OVR_OVER: begin
          if (app_rx_overrun_ack) begin
            ovr_state <= OVR_WAIT;
          end
        end
        OVR_WAIT: begin
          // ack released and the cut frame has drained from the filter
          if (!app_rx_overrun_ack && !mid_frame && !pay_valid) begin
            ovr_state <= OVR_RUN;
          end
        end
        default: begin
          ovr_state <= OVR_RUN;
        end
      endcase
    end
  end

  // writing only resumes at the start of a new frame
  a_resume_at_frame_start: assert property (
    @(posedge mac_clk) disable iff (mac_rst)
    (data_wr_en && mid_frame) |-> ($past(ovr_state) == OVR_RUN)
  );

endmodule

// File: hdl/rx_header_filter.sv
`include "udp_rx_settings.svh"

module rx_header_filter (
  input  logic                   mac_clk,
  input  logic                   mac_rst,
  input  logic [63:0]            mac_rx_data,
  input  logic [7:0]             mac_rx_data_valid,
  input  logic                   mac_rx_good_frame,
  input  logic                   mac_rx_bad_frame,
  input  logic                   phy_rx_up,
  input  logic                   local_enable,
  input  udp_rx_pkg::mac_addr_t  local_mac,
  input  udp_rx_pkg::ipv4_addr_t local_ip,
  input  udp_rx_pkg::udp_port_t  local_port,
  input  udp_rx_pkg::ipv4_addr_t local_mc_recv_ip,
  input  udp_rx_pkg::ipv4_addr_t local_mc_recv_ip_mask,
  output logic                   pay_valid,
  output logic [63:0]            pay_data,
  output logic                   pay_good,
  output logic                   pay_bad,
  output udp_rx_pkg::ipv4_addr_t src_ip,
  output udp_rx_pkg::udp_port_t  src_port
);

  import udp_rx_pkg::*;

  // two register stages on the MAC side, d1 holds the newer beat
  logic [63:0] rx_data_d1;
  logic [63:0] rx_data_d2;
  logic [7:0]  rx_valid_d1;

  rx_state_t rx_state;
  logic      accept;

  mac_addr_t  dst_mac;
  ipv4_addr_t dst_ip;
  udp_port_t  dst_port;
  logic       mac_ok;
  logic       type_ok;
  logic       proto_ok;
  logic       port_ok;
  logic       ip_ok;
  logic       frame_end;
  logic       word_ok;

  // wire byte 0 sits in the low lane, fields are rebuilt msb first
  assign dst_mac = {rx_data_d1[7:0], rx_data_d1[15:8], rx_data_d1[23:16],
                    rx_data_d1[31:24], rx_data_d1[39:32], rx_data_d1[47:40]};

  // destination IP straddles beats 3 and 4
  assign dst_ip = {rx_data_d2[55:48], rx_data_d2[63:56],
                   rx_data_d1[7:0], rx_data_d1[15:8]};

  assign dst_port = {rx_data_d1[39:32], rx_data_d1[47:40]};

  assign mac_ok = (dst_mac == local_mac) || (dst_mac == '1) ||
                  (dst_mac[47:24] == `RX_MC_MAC_PREFIX);

  assign type_ok = ({rx_data_d1[39:32], rx_data_d1[47:40]} == `RX_ETHERTYPE_IPV4) &&
                   (rx_data_d1[55:48] == `RX_IPV4_VER_IHL);

  assign proto_ok = rx_data_d1[63:56] == `RX_IP_PROTO_UDP;

  assign port_ok = dst_port == local_port;

  // our own address, or a subscribed multicast group
  assign ip_ok = (dst_ip == local_ip) ||
                 ((dst_ip & local_mc_recv_ip_mask) ==
                  (local_mc_recv_ip & local_mc_recv_ip_mask));

  assign frame_end = mac_rx_good_frame || mac_rx_bad_frame;

  // in data state d1 always holds a beat of the current frame
  assign word_ok = (rx_state == RX_DATA) && accept;

  always_ff @(posedge mac_clk) begin
    rx_data_d1 <= mac_rx_data;
    rx_data_d2 <= rx_data_d1;

    // six bytes from the older beat, two from the newer one
    pay_data <= {rx_data_d2[23:16], rx_data_d2[31:24], rx_data_d2[39:32],
                 rx_data_d2[47:40], rx_data_d2[55:48], rx_data_d2[63:56],
                 rx_data_d1[7:0], rx_data_d1[15:8]};

    if (rx_state == RX_HDR4) begin
      src_ip <= {rx_data_d1[23:16], rx_data_d1[31:24],
                 rx_data_d1[39:32], rx_data_d1[47:40]};
    end
    if (rx_state == RX_HDR5) begin
      src_port <= {rx_data_d1[23:16], rx_data_d1[31:24]};
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      rx_valid_d1 <= '0;
      rx_state    <= RX_IDLE;
      accept      <= 1'b0;
      pay_valid   <= 1'b0;
      pay_good    <= 1'b0;
      pay_bad     <= 1'b0;
    end else begin
      rx_valid_d1 <= mac_rx_data_valid;

      // the end strobe lines up with the word built from the last beat
      pay_valid <= word_ok;
      pay_good  <= word_ok && mac_rx_good_frame;
      pay_bad   <= word_ok && mac_rx_bad_frame;

      case (rx_state)
        RX_IDLE: begin
          if (rx_valid_d1 == '1) begin
            rx_state <= RX_HDR2;
            accept   <= phy_rx_up && mac_ok;
          end
        end
        RX_HDR2: begin
          rx_state <= RX_HDR3;
          if (!type_ok) begin
            accept <= 1'b0;
          end
        end
        RX_HDR3: begin
          rx_state <= RX_HDR4;
          if (!proto_ok) begin
            accept <= 1'b0;
          end
        end
        RX_HDR4: begin
          rx_state <= RX_HDR5;
        end
        RX_HDR5: begin
          rx_state <= RX_HDR6;
          if (!port_ok || !ip_ok) begin
            accept <= 1'b0;
          end
        end
        RX_HDR6: begin
          // UDP length and checksum are not checked
          rx_state <= RX_DATA;
        end
        RX_DATA: begin
          rx_state <= RX_DATA;
        end
        default: begin
          rx_state <= RX_IDLE;
        end
      endcase

      // short or rejected frames also wait here for their end strobe
      if (frame_end && rx_state != RX_IDLE) begin
        rx_state <= RX_IDLE;
      end

      // once payload flows the frame runs to its end
      if (!local_enable && rx_state != RX_DATA) begin
        accept <= 1'b0;
      end
    end
  end

  a_single_end_strobe: assert property (
    @(posedge mac_clk) disable iff (mac_rst)
    !(mac_rx_good_frame && mac_rx_bad_frame)
  );

endmodule

// File: hdl/rx_sync_fifo.sv
module rx_sync_fifo #(
  parameter type payload_t = udp_rx_pkg::app_word_t,
  parameter int  DEPTH     = 16,
  parameter int  AFULL     = DEPTH - 4
) (
  input  logic     mac_clk,
  input  logic     mac_rst,
  input  logic     wr_en,
  input  payload_t wr_data,
  input  logic     rd_en,
  output payload_t rd_data,
  output logic     empty,
  output logic     almost_full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign full        = count == CW'(DEPTH);
  assign empty       = count == '0;
  assign almost_full = count >= CW'(AFULL);
  assign do_wr       = wr_en && !full;
  assign do_rd       = rd_en && !empty;

  // first word fall through, the head is always on the read port
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the writer stops at almost-full, so the top entries stay spare
  a_no_overflow: assert property (
    @(posedge mac_clk) disable iff (mac_rst)
    !(wr_en && full)
  );

  a_no_underflow: assert property (
    @(posedge mac_clk) disable iff (mac_rst)
    !(rd_en && empty)
  );

endmodule

// File: hdl/udp_rx_pkg.sv
package udp_rx_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] udp_port_t;

  // one entry of the payload FIFO, flags above the data
  typedef struct packed {
    logic        overrun;
    logic        bad;
    logic        eof;
    logic [63:0] data;
  } app_word_t;

  // one entry of the metadata FIFO, written once per frame
  typedef struct packed {
    udp_port_t  src_port;
    ipv4_addr_t src_ip;
  } app_meta_t;

  // header walk, one state per 8-byte beat
  typedef enum logic [2:0] {
    RX_IDLE = 3'd0,
    RX_HDR2 = 3'd1,
    RX_HDR3 = 3'd2,
    RX_HDR4 = 3'd3,
    RX_HDR5 = 3'd4,
    RX_HDR6 = 3'd5,
    RX_DATA = 3'd6
  } rx_state_t;

  typedef enum logic [1:0] {
    OVR_RUN  = 2'd0,
    OVR_OVER = 2'd1,
    OVR_WAIT = 2'd2
  } ovr_state_t;

endpackage

// File: hdl/udp_rx_settings.svh
`ifndef UDP_RX_SETTINGS_SVH
`define UDP_RX_SETTINGS_SVH

// payload FIFO, one 64-bit word per entry
`define RX_DATA_FIFO_DEPTH 64
// headroom above this level absorbs the word that cuts a frame
`define RX_DATA_FIFO_AFULL 56

// metadata FIFO, one entry per delivered frame
`define RX_META_FIFO_DEPTH 16
`define RX_META_FIFO_AFULL 12

// ethertype for IPv4, in wire order
`define RX_ETHERTYPE_IPV4 16'h0800

// version 4 with a 20-byte header, no IP options
`define RX_IPV4_VER_IHL 8'h45

// IP protocol number for UDP
`define RX_IP_PROTO_UDP 8'h11

// upper half of every IPv4 multicast MAC address
`define RX_MC_MAC_PREFIX 24'h01005E

`endif

// File: hdl/udp_rx_top.sv
`include "udp_rx_settings.svh"

module udp_rx_top (
  input  logic                   mac_clk,
  input  logic                   mac_rst,
  input  logic [63:0]            mac_rx_data,
  input  logic [7:0]             mac_rx_data_valid,
  input  logic                   mac_rx_good_frame,
  input  logic                   mac_rx_bad_frame,
  input  logic                   phy_rx_up,
  input  logic                   local_enable,
  input  udp_rx_pkg::mac_addr_t  local_mac,
  input  udp_rx_pkg::ipv4_addr_t local_ip,
  input  udp_rx_pkg::udp_port_t  local_port,
  input  udp_rx_pkg::ipv4_addr_t local_mc_recv_ip,
  input  udp_rx_pkg::ipv4_addr_t local_mc_recv_ip_mask,
  output logic                   app_rx_valid,
  output logic                   app_rx_end_of_frame,
  output logic [63:0]            app_rx_data,
  output udp_rx_pkg::ipv4_addr_t app_rx_source_ip,
  output udp_rx_pkg::udp_port_t  app_rx_source_port,
  output logic                   app_rx_bad_frame,
  output logic                   app_rx_overrun,
  input  logic                   app_rx_overrun_ack,
  input  logic                   app_rx_ack
);

  import udp_rx_pkg::*;

  logic       pay_valid;
  logic [63:0] pay_data;
  logic       pay_good;
  logic       pay_bad;
  ipv4_addr_t src_ip;
  udp_port_t  src_port;

  logic       data_wr_en;
  app_word_t  data_wr;
  logic       data_rd_en;
  app_word_t  data_rd;
  logic       data_empty;
  logic       data_afull;

  logic       meta_wr_en;
  app_meta_t  meta_wr;
  logic       meta_rd_en;
  app_meta_t  meta_rd;
  logic       meta_afull;

  rx_header_filter header_filter (
    .mac_clk               (mac_clk),
    .mac_rst               (mac_rst),
    .mac_rx_data           (mac_rx_data),
    .mac_rx_data_valid     (mac_rx_data_valid),
    .mac_rx_good_frame     (mac_rx_good_frame),
    .mac_rx_bad_frame      (mac_rx_bad_frame),
    .phy_rx_up             (phy_rx_up),
    .local_enable          (local_enable),
    .local_mac             (local_mac),
    .local_ip              (local_ip),
    .local_port            (local_port),
    .local_mc_recv_ip      (local_mc_recv_ip),
    .local_mc_recv_ip_mask (local_mc_recv_ip_mask),
    .pay_valid             (pay_valid),
    .pay_data              (pay_data),
    .pay_good              (pay_good),
    .pay_bad               (pay_bad),
    .src_ip                (src_ip),
    .src_port              (src_port)
  );

  rx_app_writer app_writer (
    .mac_clk            (mac_clk),
    .mac_rst            (mac_rst),
    .pay_valid          (pay_valid),
    .pay_data           (pay_data),
    .pay_good           (pay_good),
    .pay_bad            (pay_bad),
    .src_ip             (src_ip),
    .src_port           (src_port),
    .data_afull         (data_afull),
    .meta_afull         (meta_afull),
    .app_rx_overrun_ack (app_rx_overrun_ack),
    .data_wr_en         (data_wr_en),
    .data_wr            (data_wr),
    .meta_wr_en         (meta_wr_en),
    .meta_wr            (meta_wr)
  );

  rx_sync_fifo #(
    .payload_t (app_word_t),
    .DEPTH     (`RX_DATA_FIFO_DEPTH),
    .AFULL     (`RX_DATA_FIFO_AFULL)
  ) data_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (data_wr_en),
    .wr_data     (data_wr),
    .rd_en       (data_rd_en),
    .rd_data     (data_rd),
    .empty       (data_empty),
    .almost_full (data_afull)
  );

  rx_sync_fifo #(
    .payload_t (app_meta_t),
    .DEPTH     (`RX_META_FIFO_DEPTH),
    .AFULL     (`RX_META_FIFO_AFULL)
  ) meta_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (meta_wr_en),
    .wr_data     (meta_wr),
    .rd_en       (meta_rd_en),
    .rd_data     (meta_rd),
    .empty       (),
    .almost_full (meta_afull)
  );

  // an ack with nothing to show is dropped
  assign data_rd_en = app_rx_ack && !data_empty;

  // metadata leaves together with the last word of its frame
  assign meta_rd_en = data_rd_en && data_rd.eof;

  assign app_rx_valid        = !data_empty;
  assign app_rx_data         = data_rd.data;
  assign app_rx_end_of_frame = data_rd.eof;
  assign app_rx_bad_frame    = data_rd.bad;
  assign app_rx_overrun      = data_rd.overrun;
  assign app_rx_source_ip    = meta_rd.src_ip;
  assign app_rx_source_port  = meta_rd.src_port;

endmodule

// File: sim/udp_rx_tb.sv
`include "udp_rx_settings.svh"

module udp_rx_tb;

  import udp_rx_pkg::*;

  logic        mac_clk;
  logic        mac_rst;
  logic [63:0] mac_rx_data;
  logic [7:0]  mac_rx_data_valid;
  logic        mac_rx_good_frame;
  logic        mac_rx_bad_frame;
  logic        phy_rx_up;
  logic        local_enable;
  mac_addr_t   local_mac;
  ipv4_addr_t  local_ip;
  udp_port_t   local_port;
  ipv4_addr_t  local_mc_recv_ip;
  ipv4_addr_t  local_mc_recv_ip_mask;
  logic        app_rx_valid;
  logic        app_rx_end_of_frame;
  logic [63:0] app_rx_data;
  ipv4_addr_t  app_rx_source_ip;
  udp_port_t   app_rx_source_port;
  logic        app_rx_bad_frame;
  logic        app_rx_overrun;
  logic        app_rx_overrun_ack;
  logic        app_rx_ack;

  // separate random streams for stimulus and for the ack pattern
  logic [31:0] stim_lfsr = 32'd76110;
  logic [31:0] ack_lfsr = 32'd76110;
  logic [2:0]  ack_bits;
  logic        ack_enable;

  // fields of the frame under construction
  mac_addr_t   tx_dst_mac;
  logic [15:0] tx_ethertype;
  logic [7:0]  tx_ver_ihl;
  logic [7:0]  tx_proto;
  ipv4_addr_t  tx_src_ip;
  ipv4_addr_t  tx_dst_ip;
  udp_port_t   tx_src_port;
  udp_port_t   tx_dst_port;
  logic [7:0]  frame_buf [0:159];

  app_word_t exp_words [$];
  app_meta_t exp_metas [$];

  // FIFO fill as the writer sees it while the application holds off
  logic hold_mode;
  logic cut_done;
  int   held_words;
  int   held_metas;

  int beats_sent;
  int cycle_count;

  udp_rx_top dut (
    .mac_clk               (mac_clk),
    .mac_rst               (mac_rst),
    .mac_rx_data           (mac_rx_data),
    .mac_rx_data_valid     (mac_rx_data_valid),
    .mac_rx_good_frame     (mac_rx_good_frame),
    .mac_rx_bad_frame      (mac_rx_bad_frame),
    .phy_rx_up             (phy_rx_up),
    .local_enable          (local_enable),
    .local_mac             (local_mac),
    .local_ip              (local_ip),
    .local_port            (local_port),
    .local_mc_recv_ip      (local_mc_recv_ip),
    .local_mc_recv_ip_mask (local_mc_recv_ip_mask),
    .app_rx_valid          (app_rx_valid),
    .app_rx_end_of_frame   (app_rx_end_of_frame),
    .app_rx_data           (app_rx_data),
    .app_rx_source_ip      (app_rx_source_ip),
    .app_rx_source_port    (app_rx_source_port),
    .app_rx_bad_frame      (app_rx_bad_frame),
    .app_rx_overrun        (app_rx_overrun),
    .app_rx_overrun_ack    (app_rx_overrun_ack),
    .app_rx_ack            (app_rx_ack)
  );

  initial mac_clk = 1'b0;
  always #2 mac_clk = ~mac_clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic stim_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
  endtask

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_value(input string name, input logic [63:0] exp_v,
                              input logic [63:0] got_v);
    $display("error at %0t: %s expected %h, got %h", $time, name, exp_v, got_v);
    stop_with_failure();
  endtask

  task automatic check_word(input app_word_t exp_w, input app_word_t got_w);
    if (got_w.data !== exp_w.data) begin
      report_value("app_rx_data", exp_w.data, got_w.data);
    end else if (got_w.eof !== exp_w.eof) begin
      report_value("app_rx_end_of_frame", 64'(exp_w.eof), 64'(got_w.eof));
    end else if (got_w.bad !== exp_w.bad) begin
      report_value("app_rx_bad_frame", 64'(exp_w.bad), 64'(got_w.bad));
    end else if (got_w.overrun !== exp_w.overrun) begin
      report_value("app_rx_overrun", 64'(exp_w.overrun), 64'(got_w.overrun));
    end
  endtask

  task automatic check_meta(input app_meta_t exp_m, input app_meta_t got_m);
    if (got_m.src_ip !== exp_m.src_ip) begin
      report_value("app_rx_source_ip", 64'(exp_m.src_ip), 64'(got_m.src_ip));
    end else if (got_m.src_port !== exp_m.src_port) begin
      report_value("app_rx_source_port", 64'(exp_m.src_port), 64'(got_m.src_port));
    end
  endtask

  // filter rules applied to the frame in frame_buf
  function automatic logic frame_accepted();
    mac_addr_t  dmac;
    ipv4_addr_t dip;
    udp_port_t  dport;
    logic       mac_hit;
    logic       ip_hit;
    logic       proto_hit;
    dmac = {frame_buf[0], frame_buf[1], frame_buf[2],
            frame_buf[3], frame_buf[4], frame_buf[5]};
    dip = {frame_buf[30], frame_buf[31], frame_buf[32], frame_buf[33]};
    dport = {frame_buf[36], frame_buf[37]};
    mac_hit = (dmac == local_mac) || (dmac == 48'hffff_ffff_ffff) ||
              (dmac[47:24] == `RX_MC_MAC_PREFIX);
    ip_hit = (dip == local_ip) ||
             ((dip & local_mc_recv_ip_mask) == (local_mc_recv_ip & local_mc_recv_ip_mask));
    proto_hit = ({frame_buf[12], frame_buf[13]} == `RX_ETHERTYPE_IPV4) &&
                (frame_buf[14] == `RX_IPV4_VER_IHL) &&
                (frame_buf[23] == `RX_IP_PROTO_UDP);
    return phy_rx_up && local_enable && mac_hit && proto_hit && ip_hit &&
           (dport == local_port);
  endfunction

  // word k covers bytes 42+8k to 49+8k, earliest byte on top
  function automatic app_word_t expected_word(input int k, input int nw, input logic bad);
    app_word_t w;
    for (int i = 0; i < 8; i++) begin
      w.data[63-8*i -: 8] = frame_buf[42 + 8*k + i];
    end
    w.eof = (k == nw - 1);
    w.bad = bad && w.eof;
    w.overrun = 1'b0;
    return w;
  endfunction

  task automatic set_unicast_fields();
    logic [31:0] v;
    tx_dst_mac   = local_mac;
    tx_ethertype = `RX_ETHERTYPE_IPV4;
    tx_ver_ihl   = `RX_IPV4_VER_IHL;
    tx_proto     = `RX_IP_PROTO_UDP;
    tx_dst_ip    = local_ip;
    tx_dst_port  = local_port;
    stim_bits(32, v);
    tx_src_ip = v;
    stim_bits(16, v);
    tx_src_port = v[15:0];
  endtask

  task automatic random_length(output int n);
    logic [31:0] v;
    stim_bits(4, v);
    n = 7 + int'(v % 14);
  endtask

  task automatic build_frame(input int n);
    logic [31:0] v;
    for (int i = 0; i < 6; i++) begin
      frame_buf[i]     = tx_dst_mac[47-8*i -: 8];
      frame_buf[6 + i] = 8'h02 + 8'(i);
    end
    frame_buf[12] = tx_ethertype[15:8];
    frame_buf[13] = tx_ethertype[7:0];
    frame_buf[14] = tx_ver_ihl;
    frame_buf[15] = 8'h00;
    {frame_buf[16], frame_buf[17]} = 16'(8*n - 14);
    for (int i = 18; i < 22; i++) begin
      frame_buf[i] = 8'h00;
    end
    frame_buf[22] = 8'h40;
    frame_buf[23] = tx_proto;
    frame_buf[24] = 8'h00;
    frame_buf[25] = 8'h00;
    for (int i = 0; i < 4; i++) begin
      frame_buf[26 + i] = tx_src_ip[31-8*i -: 8];
      frame_buf[30 + i] = tx_dst_ip[31-8*i -: 8];
    end
    {frame_buf[34], frame_buf[35]} = tx_src_port;
    {frame_buf[36], frame_buf[37]} = tx_dst_port;
    {frame_buf[38], frame_buf[39]} = 16'(8*n - 34);
    frame_buf[40] = 8'h00;
    frame_buf[41] = 8'h00;
    for (int i = 42; i < 8*n; i++) begin
      stim_bits(8, v);
      frame_buf[i] = v[7:0];
    end
  endtask

  task automatic queue_expected(input int n, input logic bad);
    int        nw;
    app_word_t w;
    app_meta_t m;
    logic      full_now;
    nw = frame_accepted() ? n - 6 : 0;
    m.src_ip = {frame_buf[26], frame_buf[27], frame_buf[28], frame_buf[29]};
    m.src_port = {frame_buf[34], frame_buf[35]};
    for (int k = 0; k < nw; k++) begin
      w = expected_word(k, nw, bad);
      if (!cut_done) begin
        if (hold_mode) begin
          // metadata of this frame is written together with its first word
          full_now = (held_words >= `RX_DATA_FIFO_AFULL) ||
                     (held_metas >= `RX_META_FIFO_AFULL);
          if (k == 0) begin
            held_metas++;
          end
          held_words++;
          if (full_now) begin
            w.overrun = 1'b1;
            w.eof = 1'b1;
            cut_done = 1'b1;
          end
        end
        if (k == 0) begin
          exp_metas.push_back(m);
        end
        exp_words.push_back(w);
      end
    end
  endtask

  task automatic drive_beat(input logic [63:0] d, input logic [7:0] v,
                            input logic good, input logic bad);
    @(posedge mac_clk);
    #1;
    mac_rx_data       = d;
    mac_rx_data_valid = v;
    mac_rx_good_frame = good;
    mac_rx_bad_frame  = bad;
  endtask

  task automatic send_frame(input int n, input logic bad);
    logic [63:0] beat;
    logic [31:0] v;
    beats_sent += n;
    for (int b = 0; b < n; b++) begin
      for (int i = 0; i < 8; i++) begin
        beat[8*i +: 8] = frame_buf[8*b + i];
      end
      drive_beat(beat, 8'hff, 1'b0, 1'b0);
    end
    // end strobe in the cycle after the last beat
    drive_beat('0, '0, !bad, bad);
    stim_bits(2, v);
    for (int g = 0; g <= int'(v); g++) begin
      drive_beat('0, '0, 1'b0, 1'b0);
    end
  endtask

  task automatic run_frame(input int n, input logic bad);
    build_frame(n);
    queue_expected(n, bad);
    send_frame(n, bad);
  endtask

  task automatic wait_drained();
    @(posedge mac_clk);
    #3;
    while (exp_words.size() != 0 || app_rx_valid) begin
      @(posedge mac_clk);
      #3;
    end
    @(posedge mac_clk);
    #1;
  endtask

  // application side ack, about seven cycles in eight
  always begin
    @(posedge mac_clk);
    #1;
    for (int i = 0; i < 3; i++) begin
      ack_lfsr = lfsr_step(ack_lfsr);
      ack_bits[i] = ack_lfsr[0];
    end
    app_rx_ack = ack_enable && (ack_bits != 3'b000);
  end

  // mid cycle, the pop happens at the next rising edge
  always @(negedge mac_clk) begin : compare_outputs
    app_word_t got_w;
    app_meta_t got_m;
    if (!mac_rst && app_rx_valid && app_rx_ack) begin
      got_w = '{overrun: app_rx_overrun, bad: app_rx_bad_frame,
                eof: app_rx_end_of_frame, data: app_rx_data};
      got_m = '{src_port: app_rx_source_port, src_ip: app_rx_source_ip};
      if (exp_words.size() == 0) begin
        $display("payload word %h was delivered at %0t when none was expected",
                 app_rx_data, $time);
        stop_with_failure();
      end else begin
        check_word(exp_words.pop_front(), got_w);
        if (got_w.eof) begin
          if (exp_metas.size() == 0) begin
            $display("frame ended at %0t with no metadata entry expected", $time);
            stop_with_failure();
          end else begin
            check_meta(exp_metas.pop_front(), got_m);
          end
        end
      end
    end
  end

  always @(posedge mac_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > 4 * beats_sent + 2000) begin
      $display("timeout after %0d cycles with %0d beats sent, %0d words still expected",
               cycle_count, beats_sent, exp_words.size());
      stop_with_failure();
    end
  end

  initial begin : main_sequence
    int n;
    mac_rst               = 1'b1;
    mac_rx_data           = '0;
    mac_rx_data_valid     = '0;
    mac_rx_good_frame     = 1'b0;
    mac_rx_bad_frame      = 1'b0;
    phy_rx_up             = 1'b1;
    local_enable          = 1'b1;
    local_mac             = 48'h02_00_00_00_00_0a;
    local_ip              = 32'hc0a8_010a;
    local_port            = 16'h1234;
    local_mc_recv_ip      = 32'he001_0200;
    local_mc_recv_ip_mask = 32'hffff_ff00;
    app_rx_overrun_ack    = 1'b0;
    app_rx_ack            = 1'b0;
    ack_enable            = 1'b0;
    hold_mode             = 1'b0;
    cut_done              = 1'b0;
    held_words            = 0;
    held_metas            = 0;
    beats_sent            = 0;
    cycle_count           = 0;

    repeat (16) @(posedge mac_clk);
    #1;
    mac_rst = 1'b0;
    ack_enable = 1'b1;
    repeat (4) @(posedge mac_clk);
    #1;

    // unicast frames to our own address
    for (int i = 0; i < 6; i++) begin
      set_unicast_fields();
      random_length(n);
      run_frame(n, 1'b0);
    end
    wait_drained();

    // one wrong header field per rejected frame, a good frame after each
    for (int f = 0; f < 6; f++) begin
      set_unicast_fields();
      case (f)
        0: tx_dst_mac = 48'h02_11_22_33_44_56;
        1: tx_ethertype = 16'h86dd;
        2: tx_ver_ihl = 8'h46;
        3: tx_proto = 8'h06;
        4: tx_dst_port = local_port + 16'd1;
        default: tx_dst_ip = 32'h0a00_0063;
      endcase
      random_length(n);
      run_frame(n, 1'b0);
      set_unicast_fields();
      random_length(n);
      run_frame(n, 1'b0);
    end
    wait_drained();

    // broadcast MAC, and multicast groups inside the mask
    set_unicast_fields();
    tx_dst_mac = 48'hffff_ffff_ffff;
    random_length(n);
    run_frame(n, 1'b0);
    set_unicast_fields();
    tx_dst_mac = 48'h01_00_5e_01_02_07;
    tx_dst_ip = 32'he001_0207;
    random_length(n);
    run_frame(n, 1'b0);
    set_unicast_fields();
    tx_dst_ip = 32'he001_02fe;
    tx_dst_mac = 48'hffff_ffff_ffff;
    random_length(n);
    run_frame(n, 1'b0);
    wait_drained();

    // frames ended by the bad strobe
    for (int i = 0; i < 3; i++) begin
      set_unicast_fields();
      random_length(n);
      run_frame(n, i != 1);
    end
    wait_drained();

    // gating by local_enable and by the PHY link
    local_enable = 1'b0;
    set_unicast_fields();
    random_length(n);
    run_frame(n, 1'b0);
    local_enable = 1'b1;
    phy_rx_up = 1'b0;
    set_unicast_fields();
    random_length(n);
    run_frame(n, 1'b0);
    phy_rx_up = 1'b1;
    set_unicast_fields();
    random_length(n);
    run_frame(n, 1'b0);
    wait_drained();

    // application stalls until the FIFOs cut a frame
    ack_enable = 1'b0;
    hold_mode = 1'b1;
    held_words = 0;
    held_metas = 0;
    cut_done = 1'b0;
    repeat (2) @(posedge mac_clk);
    #1;
    for (int i = 0; i < 16; i++) begin
      set_unicast_fields();
      random_length(n);
      run_frame(n, 1'b0);
    end
    ack_enable = 1'b1;
    wait_drained();
    app_rx_overrun_ack = 1'b1;
    repeat (4) @(posedge mac_clk);
    #1;
    app_rx_overrun_ack = 1'b0;
    repeat (4) @(posedge mac_clk);
    #1;
    hold_mode = 1'b0;
    cut_done = 1'b0;
    set_unicast_fields();
    random_length(n);
    run_frame(n, 1'b0);
    wait_drained();

    repeat (20) @(posedge mac_clk);
    #1;
    if (exp_words.size() != 0 || exp_metas.size() != 0 || app_rx_valid) begin
      $display("run ended with %0d words and %0d metadata entries undelivered",
               exp_words.size(), exp_metas.size());
      stop_with_failure();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// File: udp_rx.f
+incdir+hdl
hdl/udp_rx_pkg.sv
hdl/rx_header_filter.sv
hdl/rx_sync_fifo.sv
hdl/rx_app_writer.sv
hdl/udp_rx_top.sv
sim/udp_rx_tb.sv
